/* logic/mem_map_pkg.sv */
// Address map, memory sizes, data word types and data address classes
package mem_map_pkg;

    // ==================================================
    // Widths
    // ==================================================
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int LANES  = WORD_W / 8;
    localparam int GPIO_W = 5;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LANES-1:0]  byte_en_t;
    typedef logic [GPIO_W-1:0] gpio_t;

    // ==================================================
    // Memory map
    // ==================================================
    // Program memory first, data RAM right behind it
    localparam addr_t PROG_MEM_SIZE = 32'h0000_2000;
    localparam addr_t DATA_MEM_SIZE = 32'h0000_2000;
    localparam addr_t MEM_SIZE      = PROG_MEM_SIZE + DATA_MEM_SIZE;
    localparam addr_t DATA_BASE     = 32'h0000_2000;

    // Sits well outside the RAM window
    localparam addr_t GPIO_ADDR     = 32'h4000_1000;

    // Byte index into the shared memory array
    localparam int MEM_AW = $clog2(MEM_SIZE);
    typedef logic [MEM_AW-1:0] mem_idx_t;

    // Class of a data address
    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_GPIO,
        REGION_NONE
    } region_e;

endpackage

/* logic/access_pkg.sv */
// Store size codes, access delays, delay counter type and access state enum
package access_pkg;

    // ==================================================
    // Store size (funct3 of the store instruction)
    // ==================================================
    localparam int FUNCT3_W = 3;

    typedef logic [FUNCT3_W-1:0] store_size_t;

    localparam store_size_t SIZE_BYTE = 3'b000;
    localparam store_size_t SIZE_HALF = 3'b001;
    localparam store_size_t SIZE_WORD = 3'b010;

    // ==================================================
    // Access timing
    // ==================================================
    localparam int DELAY_W = 3;

    typedef logic [DELAY_W-1:0] delay_t;

    // Cycles from acceptance to the ready edge
    localparam delay_t INSTR_FETCH_DELAY = 3'd3;
    localparam delay_t DATA_ACCESS_DELAY = 3'd2;

    // Sequencer state
    typedef enum logic {
        ACCESS_IDLE,
        ACCESS_ACTIVE
    } access_state_e;

endpackage

/* logic/access_decode.sv */
// Data address classifier, fetch range check and store byte-enable expansion
`timescale 1ns/1ps

module access_decode (
    input  mem_map_pkg::addr_t        instr_addr,
    input  mem_map_pkg::addr_t        mem_addr,
    input  access_pkg::store_size_t   mem_flag,
    output mem_map_pkg::region_e      region,
    output mem_map_pkg::byte_en_t     byte_en,
    output logic                      instr_in_range
);

    logic in_ram;
    logic is_gpio;

    // ==================================================
    // Data address class
    // ==================================================
    // Only the data RAM half is reachable through the data port
    assign in_ram  = (mem_addr >= mem_map_pkg::DATA_BASE) &&
                     (mem_addr <  mem_map_pkg::MEM_SIZE);
    assign is_gpio = (mem_addr == mem_map_pkg::GPIO_ADDR);

    always_comb begin
        if (in_ram) begin
            region = mem_map_pkg::REGION_RAM;
        end else if (is_gpio) begin
            region = mem_map_pkg::REGION_GPIO;
        end else begin
            region = mem_map_pkg::REGION_NONE;
        end
    end

    // Fetches may come from program memory or data RAM
    assign instr_in_range = (instr_addr < mem_map_pkg::MEM_SIZE);

    // ==================================================
    // Store lane enables
    // ==================================================
    always_comb begin
        case (mem_flag)
            access_pkg::SIZE_BYTE: begin
                byte_en = 4'b0001;
            end
            access_pkg::SIZE_HALF: begin
                byte_en = 4'b0011;
            end
            access_pkg::SIZE_WORD: begin
                byte_en = 4'b1111;
            end
            default: begin
                // Unknown code falls back to a byte store
                byte_en = 4'b0001;
            end
        endcase
    end

endmodule

/* logic/access_sequencer.sv */
// Request arbiter with data priority, access field latches and delay counter
`timescale 1ns/1ps

module access_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mem_we,
    input  logic                    mem_re,
    input  mem_map_pkg::addr_t      mem_addr,
    input  mem_map_pkg::word_t      mem_wdata,
    input  mem_map_pkg::region_e    region,
    input  mem_map_pkg::byte_en_t   byte_en,
    input  mem_map_pkg::addr_t      instr_addr,
    input  logic                    instr_in_range,
    output logic                    commit,
    output logic                    cur_is_instr,
    output logic                    cur_we,
    output mem_map_pkg::addr_t      cur_addr,
    output mem_map_pkg::word_t      cur_wdata,
    output mem_map_pkg::byte_en_t   cur_byte_en,
    output mem_map_pkg::region_e    cur_region,
    output logic                    cur_in_range
);

    access_pkg::access_state_e state;
    access_pkg::delay_t        count;

    logic data_req;
    logic start_data;
    logic start_instr;
    logic gpio_now;

    // Fields captured at acceptance
    logic                    is_instr_q;
    logic                    we_q;
    logic                    in_range_q;
    mem_map_pkg::addr_t      addr_q;
    mem_map_pkg::word_t      wdata_q;
    mem_map_pkg::byte_en_t   byte_en_q;
    mem_map_pkg::region_e    region_q;

    // ==================================================
    // Arbitration
    // ==================================================
    assign data_req    = mem_we || mem_re;
    assign start_data  = (state == access_pkg::ACCESS_IDLE) && data_req;
    assign start_instr = (state == access_pkg::ACCESS_IDLE) && !data_req;

    // GPIO finishes in the same cycle it is taken
    assign gpio_now = start_data && (region == mem_map_pkg::REGION_GPIO);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= access_pkg::ACCESS_IDLE;
            count      <= '0;
            is_instr_q <= 1'b0;
            we_q       <= 1'b0;
        end else begin
            case (state)
                access_pkg::ACCESS_IDLE: begin
                    if (start_data) begin
                        is_instr_q <= 1'b0;
                        we_q       <= mem_we;
                        if (!gpio_now) begin
                            state <= access_pkg::ACCESS_ACTIVE;
                            count <= access_pkg::DATA_ACCESS_DELAY - 3'd1;
                        end
                    end else if (start_instr) begin
                        is_instr_q <= 1'b1;
                        we_q       <= 1'b0;
                        state      <= access_pkg::ACCESS_ACTIVE;
                        count      <= access_pkg::INSTR_FETCH_DELAY - 3'd1;
                    end
                end
                access_pkg::ACCESS_ACTIVE: begin
                    if (count == '0) begin
                        state <= access_pkg::ACCESS_IDLE;
                    end else begin
                        count <= count - 3'd1;
                    end
                end
                default: begin
                    state <= access_pkg::ACCESS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_data) begin
            addr_q     <= mem_addr;
            wdata_q    <= mem_wdata;
            byte_en_q  <= byte_en;
            region_q   <= region;
            in_range_q <= (region == mem_map_pkg::REGION_RAM);
        end else if (start_instr) begin
            addr_q     <= instr_addr;
            wdata_q    <= '0;
            byte_en_q  <= '0;
            region_q   <= mem_map_pkg::REGION_NONE;
            in_range_q <= instr_in_range;
        end
    end

    // ==================================================
    // Commit to the result stage
    // ==================================================
    assign commit = gpio_now ||
                    ((state == access_pkg::ACCESS_ACTIVE) && (count == '0));

    // Live request fields for GPIO, latched ones otherwise
    always_comb begin
        if (gpio_now) begin
            cur_is_instr = 1'b0;
            cur_we       = mem_we;
            cur_addr     = mem_addr;
            cur_wdata    = mem_wdata;
            cur_byte_en  = byte_en;
            cur_region   = region;
            cur_in_range = 1'b0;
        end else begin
            cur_is_instr = is_instr_q;
            cur_we       = we_q;
            cur_addr     = addr_q;
            cur_wdata    = wdata_q;
            cur_byte_en  = byte_en_q;
            cur_region   = region_q;
            cur_in_range = in_range_q;
        end
    end

    // Idle commits only come from a data request at the GPIO address
    a_idle_commit_gpio: assert property (@(posedge clk) disable iff (!rst_n)
        (commit && (state == access_pkg::ACCESS_IDLE)) |->
            (data_req && (mem_addr == mem_map_pkg::GPIO_ADDR)))
        else $error("access_sequencer: commit while idle for a non-GPIO access");

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= access_pkg::INSTR_FETCH_DELAY)
        else $error("access_sequencer: delay counter out of range");

endmodule

/* logic/mem_result.sv */
// Byte memory, GPIO register, read data registers and ready pulse generation
`timescale 1ns/1ps

module mem_result (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    commit,
    input  logic                    cur_is_instr,
    input  logic                    cur_we,
    input  mem_map_pkg::addr_t      cur_addr,
    input  mem_map_pkg::word_t      cur_wdata,
    input  mem_map_pkg::byte_en_t   cur_byte_en,
    input  mem_map_pkg::region_e    cur_region,
    input  logic                    cur_in_range,
    output mem_map_pkg::word_t      instr_data,
    output logic                    instr_ready,
    output mem_map_pkg::word_t      mem_rdata,
    output logic                    mem_ready,
    output mem_map_pkg::gpio_t      gpio_out
);

    // Shared program and data memory, little-endian bytes
    logic [7:0] mem [0:mem_map_pkg::MEM_SIZE-1];

    mem_map_pkg::mem_idx_t lane_idx [mem_map_pkg::LANES];
    mem_map_pkg::word_t    rd_word;
    mem_map_pkg::gpio_t    gpio_reg;
    logic                  ram_write;

    initial begin
        for (int i = 0; i < mem_map_pkg::MEM_SIZE; i++) begin
            mem[i] = 8'h00;
        end
    end

    // ==================================================
    // Lane addressing and word read
    // ==================================================
    // Index wraps inside the array at the top end
    always_comb begin
        for (int i = 0; i < mem_map_pkg::LANES; i++) begin
            lane_idx[i] = mem_map_pkg::mem_idx_t'(cur_addr) + mem_map_pkg::mem_idx_t'(i);
            rd_word[8*i +: 8] = mem[lane_idx[i]];
        end
    end

    assign ram_write = commit && !cur_is_instr && cur_we &&
                       (cur_region == mem_map_pkg::REGION_RAM);

    always @(posedge clk) begin
        if (ram_write) begin
            for (int i = 0; i < mem_map_pkg::LANES; i++) begin
                if (cur_byte_en[i]) begin
                    mem[lane_idx[i]] <= cur_wdata[8*i +: 8];
                end
            end
        end
    end

    // ==================================================
    // Output registers
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_data  <= '0;
            instr_ready <= 1'b0;
            mem_rdata   <= '0;
            mem_ready   <= 1'b0;
            gpio_reg    <= '0;
        end else begin
            // Ready is a one-cycle pulse per commit
            instr_ready <= commit && cur_is_instr;
            mem_ready   <= commit && !cur_is_instr;

            if (commit) begin
                if (cur_is_instr) begin
                    instr_data <= cur_in_range ? rd_word : '0;
                end else if (cur_region == mem_map_pkg::REGION_GPIO) begin
                    if (cur_we) begin
                        gpio_reg <= mem_map_pkg::gpio_t'(cur_wdata);
                    end else begin
                        mem_rdata <= mem_map_pkg::word_t'(gpio_reg);
                    end
                end else if (!cur_we) begin
                    // Unmapped reads come back as zero
                    mem_rdata <= (cur_region == mem_map_pkg::REGION_RAM) ? rd_word : '0;
                end
            end
        end
    end

    assign gpio_out = gpio_reg;

    // A fetch spans three cycles, so no data ready can sit right before its ready
    a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
        instr_ready |-> (!mem_ready && !$past(mem_ready)))
        else $error("mem_result: fetch ready overlaps or directly follows a data ready");

    a_instr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        instr_ready |=> !instr_ready)
        else $error("mem_result: instr_ready held for two cycles");

    a_mem_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |=> !mem_ready)
        else $error("mem_result: mem_ready held for two cycles");

endmodule

/* logic/mem_ctl.sv */
// Memory controller top level joining decode, sequencer and result stages
`timescale 1ns/1ps

module mem_ctl (
    input  logic                      clk,
    input  logic                      rst_n,
    // Instruction fetch port
    input  mem_map_pkg::addr_t        instr_addr,
    output mem_map_pkg::word_t        instr_data,
    output logic                      instr_ready,
    // Data port
    input  mem_map_pkg::addr_t        mem_addr,
    input  mem_map_pkg::word_t        mem_wdata,
    input  access_pkg::store_size_t   mem_flag,
    input  logic                      mem_we,
    input  logic                      mem_re,
    output mem_map_pkg::word_t        mem_rdata,
    output logic                      mem_ready,
    // GPIO pins
    output mem_map_pkg::gpio_t        gpio_out
);

    // Decode to sequencer
    mem_map_pkg::region_e    region;
    mem_map_pkg::byte_en_t   byte_en;
    logic                    instr_in_range;

    // Sequencer to result stage
    logic                    commit;
    logic                    cur_is_instr;
    logic                    cur_we;
    mem_map_pkg::addr_t      cur_addr;
    mem_map_pkg::word_t      cur_wdata;
    mem_map_pkg::byte_en_t   cur_byte_en;
    mem_map_pkg::region_e    cur_region;
    logic                    cur_in_range;

    access_decode u_decode (
        .instr_addr     (instr_addr),
        .mem_addr       (mem_addr),
        .mem_flag       (mem_flag),
        .region         (region),
        .byte_en        (byte_en),
        .instr_in_range (instr_in_range)
    );

    access_sequencer u_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_we         (mem_we),
        .mem_re         (mem_re),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .region         (region),
        .byte_en        (byte_en),
        .instr_addr     (instr_addr),
        .instr_in_range (instr_in_range),
        .commit         (commit),
        .cur_is_instr   (cur_is_instr),
        .cur_we         (cur_we),
        .cur_addr       (cur_addr),
        .cur_wdata      (cur_wdata),
        .cur_byte_en    (cur_byte_en),
        .cur_region     (cur_region),
        .cur_in_range   (cur_in_range)
    );

    mem_result u_result (
        .clk            (clk),
        .rst_n          (rst_n),
        .commit         (commit),
        .cur_is_instr   (cur_is_instr),
        .cur_we         (cur_we),
        .cur_addr       (cur_addr),
        .cur_wdata      (cur_wdata),
        .cur_byte_en    (cur_byte_en),
        .cur_region     (cur_region),
        .cur_in_range   (cur_in_range),
        .instr_data     (instr_data),
        .instr_ready    (instr_ready),
        .mem_rdata      (mem_rdata),
        .mem_ready      (mem_ready),
        .gpio_out       (gpio_out)
    );

endmodule

/* tb/tb_mem_ctl.sv */
// Directed testbench for the memory controller with access tasks, compare tasks and timeout
`timescale 1ns/1ps

module tb_mem_ctl;

    localparam int NUM_ACCESSES    = 40;
    localparam int TIMEOUT_CYCLES  = 20 * NUM_ACCESSES;
    localparam int MAX_DATA_EDGES  = 6;
    localparam int MAX_FETCH_EDGES = 12;

    logic                    clk;
    logic                    rst_n;
    mem_map_pkg::addr_t      instr_addr;
    mem_map_pkg::word_t      instr_data;
    logic                    instr_ready;
    mem_map_pkg::addr_t      mem_addr;
    mem_map_pkg::word_t      mem_wdata;
    access_pkg::store_size_t mem_flag;
    logic                    mem_we;
    logic                    mem_re;
    mem_map_pkg::word_t      mem_rdata;
    logic                    mem_ready;
    mem_map_pkg::gpio_t      gpio_out;

    int     value_errors;
    int     protocol_errors;
    int     cycles;
    integer seed;

    // Expected data RAM words by aligned address, missing entries read as zero
    mem_map_pkg::word_t model [mem_map_pkg::addr_t];
    mem_map_pkg::gpio_t exp_gpio;

    mem_ctl uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_addr  (instr_addr),
        .instr_data  (instr_data),
        .instr_ready (instr_ready),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_flag    (mem_flag),
        .mem_we      (mem_we),
        .mem_re      (mem_re),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .gpio_out    (gpio_out)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // ==================================================
    // Compare tasks and reference model
    // ==================================================
    task automatic check_word(input mem_map_pkg::word_t actual,
                              input mem_map_pkg::word_t expected, input string what);
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_gpio(input mem_map_pkg::gpio_t actual,
                              input mem_map_pkg::gpio_t expected, input string what);
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            value_errors++;
            $display("[FAIL] %0t ns: %s got %b, expected %b", $time, what, actual, expected);
        end
    endtask

    function automatic logic is_ram(input mem_map_pkg::addr_t addr);
        return (addr >= 32'h0000_2000) && (addr < 32'h0000_4000);
    endfunction

    function automatic mem_map_pkg::word_t expected_word(input mem_map_pkg::addr_t addr);
        return model.exists(addr) ? model[addr] : 32'h0;
    endfunction

    // Little-endian lane replacement for a store code
    function automatic mem_map_pkg::word_t merge_store(input mem_map_pkg::word_t old_word,
                                                       input mem_map_pkg::word_t data,
                                                       input access_pkg::store_size_t size);
        mem_map_pkg::word_t result;
        result = old_word;
        if (size == 3'b010) begin
            result = data;
        end else if (size == 3'b001) begin
            result[15:0] = data[15:0];
        end else begin
            // Byte store, and unknown codes behave the same
            result[7:0] = data[7:0];
        end
        return result;
    endfunction

    // ==================================================
    // Bus tasks, entered and left on a falling edge
    // ==================================================
    task automatic data_access(input logic we, input mem_map_pkg::addr_t addr,
                               input mem_map_pkg::word_t wdata,
                               input access_pkg::store_size_t size,
                               output mem_map_pkg::word_t rdata, output int edges);
        // Let the previous ready pulse clear first
        if (mem_ready) begin
            @(posedge clk);
            @(negedge clk);
        end
        mem_addr  = addr;
        mem_wdata = wdata;
        mem_flag  = size;
        mem_we    = we;
        mem_re    = !we;
        edges     = 0;
        rdata     = '0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!mem_ready && edges < MAX_DATA_EDGES);
        if (mem_ready) begin
            rdata = mem_rdata;
        end else begin
            protocol_errors++;
            $display("Error at %0t ns: no mem_ready within %0d edges for address %h",
                     $time, MAX_DATA_EDGES, addr);
        end
        mem_we = 1'b0;
        mem_re = 1'b0;
    endtask

    task automatic data_write(input mem_map_pkg::addr_t addr, input mem_map_pkg::word_t wdata,
                              input access_pkg::store_size_t size);
        mem_map_pkg::word_t unused;
        int                 edges;
        data_access(1'b1, addr, wdata, size, unused, edges);
        if (is_ram(addr)) begin
            model[addr] = merge_store(expected_word(addr), wdata, size);
        end else if (addr == 32'h4000_1000) begin
            exp_gpio = wdata[4:0];
        end
    endtask

    task automatic data_read(input mem_map_pkg::addr_t addr, input string what);
        mem_map_pkg::word_t rdata;
        mem_map_pkg::word_t expected;
        int                 edges;
        data_access(1'b0, addr, '0, 3'b010, rdata, edges);
        if (is_ram(addr)) begin
            expected = expected_word(addr);
        end else if (addr == 32'h4000_1000) begin
            expected = {27'h0, exp_gpio};
        end else begin
            expected = '0;
        end
        check_word(rdata, expected, what);
    endtask

    task automatic wait_instr(input mem_map_pkg::addr_t addr, input string what);
        int                 edges;
        int                 pulses;
        mem_map_pkg::word_t expected;
        instr_addr = addr;
        edges      = 0;
        pulses     = 0;
        // The first pulse may still belong to the previous address
        while (pulses < 2 && edges < MAX_FETCH_EDGES) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (instr_ready) begin
                pulses++;
            end
        end
        expected = (addr < 32'h0000_4000) ? expected_word(addr) : 32'h0;
        if (pulses == 2) begin
            check_word(instr_data, expected, what);
        end else begin
            protocol_errors++;
            $display("Error at %0t ns: fetch from %h never got instr_ready", $time, addr);
        end
    endtask

    // Returns on the falling edge that shows a fetch ready pulse
    task automatic align_to_fetch_ready();
        int edges;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!instr_ready && edges < MAX_FETCH_EDGES);
        if (!instr_ready) begin
            protocol_errors++;
            $display("Error at %0t ns: no instr_ready within %0d edges",
                     $time, MAX_FETCH_EDGES);
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_reset_state();
        check_bit(mem_ready, 1'b0, "mem_ready after reset");
        check_bit(instr_ready, 1'b0, "instr_ready after reset");
        check_gpio(gpio_out, 5'h00, "gpio_out after reset");
        check_word(mem_rdata, 32'h0, "mem_rdata after reset");
        check_word(instr_data, 32'h0, "instr_data after reset");
    endtask

    task automatic test_word_store_load();
        mem_map_pkg::addr_t addrs [4];
        addrs = '{32'h2000, 32'h2004, 32'h2100, 32'h3FFC};
        foreach (addrs[i]) begin
            data_write(addrs[i], $random(seed), 3'b010);
        end
        foreach (addrs[i]) begin
            data_read(addrs[i], "word load");
        end
    endtask

    task automatic test_sub_word_stores();
        data_write(32'h2200, 32'hA1B2_C3D4, 3'b010);
        data_write(32'h2200, $random(seed), 3'b000);
        data_read(32'h2200, "load after byte store");
        data_write(32'h2200, $random(seed), 3'b001);
        data_read(32'h2200, "load after halfword store");
        data_write(32'h2200, $random(seed), 3'b111);
        data_read(32'h2200, "load after unknown store code");
    endtask

    task automatic test_gpio();
        mem_map_pkg::word_t rdata;
        int                 edges;
        data_write(32'h4000_1000, $random(seed), 3'b010);
        check_gpio(gpio_out, exp_gpio, "gpio_out after write");
        // A fetch has just finished, so the sequencer is idle at the next edge
        align_to_fetch_ready();
        data_access(1'b0, 32'h4000_1000, '0, 3'b010, rdata, edges);
        check_word(rdata, {27'h0, exp_gpio}, "GPIO read");
        check_bit(edges == 1, 1'b1, "GPIO read done in one edge");
    endtask

    task automatic test_fetch_stored_code();
        for (int i = 0; i < 3; i++) begin
            data_write(32'h2400 + 4 * i, $random(seed), 3'b010);
        end
        for (int i = 0; i < 3; i++) begin
            wait_instr(32'h2400 + 4 * i, "fetch of stored code");
        end
        // A data read lands in the middle of the repeating fetches
        @(posedge clk);
        @(negedge clk);
        data_read(32'h2000, "load during fetching");
        wait_instr(32'h2404, "fetch after data load");
        // Low address bits match the stored code above
        wait_instr(32'h0001_2400, "fetch outside memory");
    endtask

    task automatic test_unmapped();
        data_write(32'h2300, $random(seed), 3'b010);
        data_write(32'h4000_1000, 32'h0000_0015, 3'b010);
        // Unmapped addresses whose low bits alias written RAM words
        data_write(32'h8000_2300, $random(seed), 3'b010);
        data_read(32'h2300, "RAM word after unmapped write");
        check_gpio(gpio_out, exp_gpio, "gpio_out after unmapped write");
        data_read(32'h0000_6000, "unmapped read");
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        instr_addr      = '0;
        mem_addr        = '0;
        mem_wdata       = '0;
        mem_flag        = 3'b010;
        mem_we          = 1'b0;
        mem_re          = 1'b0;
        value_errors    = 0;
        protocol_errors = 0;
        cycles          = 0;
        seed            = 66;
        exp_gpio        = '0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_word_store_load();
        test_sub_word_stores();
        test_gpio();
        test_fetch_stored_code();
        test_unmapped();

        $display("Done: %0d value errors, %0d protocol errors", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/mem_map_pkg.sv
logic/access_pkg.sv
logic/access_decode.sv
logic/access_sequencer.sv
logic/mem_result.sv
logic/mem_ctl.sv
tb/tb_mem_ctl.sv
